// File: aluUnit.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module aluUnit import cpu_pkg::*; (
  input  logic   clk,
  input  logic   Reset,
  input  logic   executeEnable,
  input  opcodeT opcode,
  input  dataT   operand1,
  input  dataT   operand2Reg,
  input  dataT   immediate,
  output dataT   result,
  output logic   zeroFlag,
  output logic   carryFlag
);

  dataT                    operand2;
  dataT                    addend;
  logic                    subtract;
  logic [`SHIFT_WIDTH-1:0] shiftAmount;
  logic [`DATA_WIDTH:0]    sumWide;     // Top bit is carry out
  dataT                    aluValue;
  logic                    aluCarry;
  logic                    updateFlags;

  //////////////////////////////
  // Operand select and adder
  //////////////////////////////

  assign operand2 = (opcode == opAddImm || opcode == opSubImm) ? immediate : operand2Reg;
  assign subtract = (opcode == opSub || opcode == opSubImm);
  assign shiftAmount = operand2[`SHIFT_WIDTH-1:0];

  // Subtract as op1 + ~op2 + 1, carry set means no borrow
  assign addend  = subtract ? ~operand2 : operand2;
  assign sumWide = {1'b0, operand1} + {1'b0, addend} + {{`DATA_WIDTH{1'b0}}, subtract};

  always_comb begin
    aluValue    = immediate;
    aluCarry    = 1'b0;
    updateFlags = 1'b1;
    case (opcode)
      opAdd, opSub, opAddImm, opSubImm: begin
        aluValue = sumWide[`DATA_WIDTH-1:0];
        aluCarry = sumWide[`DATA_WIDTH];
      end
      opAnd: aluValue = operand1 & operand2;
      opOr:  aluValue = operand1 | operand2;
      opXor: aluValue = operand1 ^ operand2;
      opShl: begin
        aluValue = operand1 << shiftAmount;
        aluCarry = operand1[`DATA_WIDTH-1];  // Edge bit shifted out first
      end
      opShr: begin
        aluValue = operand1 >> shiftAmount;
        aluCarry = operand1[0];
      end
      default: begin
        // Load immediate, also for unused codes
        updateFlags = 1'b0;
      end
    endcase
  end

  //////////////////////////////
  // Result and flag registers
  //////////////////////////////

  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      result    <= '0;
      zeroFlag  <= 1'b0;
      carryFlag <= 1'b0;
    end else if (executeEnable) begin
      result <= aluValue;
      if (updateFlags) begin
        zeroFlag  <= (aluValue == '0);
        carryFlag <= aluCarry;
      end
    end
  end

endmodule

// File: cpuCore.sv
`timescale 1ns/1ps

module cpuCore import cpu_pkg::*; (
  input  logic    clk,
  input  logic    Reset,
  // Instruction handshake
  input  logic    instrValid,
  output logic    instrReady,
  input  opcodeT  instrOpcode,
  input  regAddrT instrDest,
  input  regAddrT instrSrc1,
  input  regAddrT instrSrc2,
  input  dataT    instrImm,
  // Result handshake
  output logic    resultValid,
  input  logic    resultReady,
  output regAddrT resultDest,
  output dataT    resultData,
  // Flags
  output logic    zeroFlag,
  output logic    carryFlag
);

  logic    readEnable;
  regAddrT readAddr1;
  regAddrT readAddr2;
  logic    executeEnable;
  opcodeT  latchedOpcode;
  dataT    latchedImm;
  logic    writeEnable;
  dataT    readData1;
  dataT    readData2;

  phaseSequencer sequencer (
    .clk(clk), .Reset(Reset),
    .instrValid(instrValid), .instrReady(instrReady), .instrOpcode(instrOpcode),
    .instrDest(instrDest), .instrSrc1(instrSrc1), .instrSrc2(instrSrc2), .instrImm(instrImm),
    .resultValid(resultValid), .resultReady(resultReady), .resultDest(resultDest),
    .readEnable(readEnable), .readAddr1(readAddr1), .readAddr2(readAddr2),
    .executeEnable(executeEnable), .latchedOpcode(latchedOpcode),
    .latchedImm(latchedImm), .writeEnable(writeEnable)
  );

  // Write data is the ALU result on offer
  registerFile regFile (
    .clk(clk), .Reset(Reset),
    .readEnable(readEnable), .readAddr1(readAddr1), .readAddr2(readAddr2),
    .writeEnable(writeEnable), .writeAddr(resultDest), .writeData(resultData),
    .readData1(readData1), .readData2(readData2)
  );

  aluUnit alu (
    .clk(clk), .Reset(Reset), .executeEnable(executeEnable),
    .opcode(latchedOpcode), .operand1(readData1), .operand2Reg(readData2),
    .immediate(latchedImm), .result(resultData),
    .zeroFlag(zeroFlag), .carryFlag(carryFlag)
  );

endmodule

// File: cpuCore_assertions.sv
`timescale 1ns/1ps

module cpuCore_assertions import cpu_pkg::*; (
  input logic    clk,
  input logic    Reset,
  input logic    instrReady,
  input logic    resultValid,
  input logic    resultReady,
  input regAddrT resultDest,
  input dataT    resultData
);

  // Offered result holds until it is taken
  resultHold: assert property (@(posedge clk) disable iff (Reset)
    resultValid && !resultReady |=> resultValid && $stable(resultDest) && $stable(resultData))
    else $error("resultValid or its fields changed before the transfer");

  // One instruction in flight
  noOverlap: assert property (@(posedge clk) disable iff (Reset)
    !(instrReady && resultValid))
    else $error("instrReady and resultValid high together");

  resultKnown: assert property (@(posedge clk) disable iff (Reset)
    resultValid |-> !$isunknown(resultData))
    else $error("resultData unknown while resultValid is high");

endmodule

bind cpuCore cpuCore_assertions handshakeChecks (
  .clk(clk), .Reset(Reset), .instrReady(instrReady), .resultValid(resultValid),
  .resultReady(resultReady), .resultDest(resultDest), .resultData(resultData)
);

// File: cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

  typedef logic [`DATA_WIDTH-1:0] dataT;
  typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT;

  // Kept ALU opcodes, every one writes its destination
  typedef enum logic [`OPCODE_WIDTH-1:0] {
    opLoadImm = 5'd0,
    opAdd     = 5'd1,
    opSub     = 5'd2,
    opAddImm  = 5'd3,
    opSubImm  = 5'd4,
    opAnd     = 5'd5,
    opOr      = 5'd6,
    opXor     = 5'd7,
    opShl     = 5'd8,
    opShr     = 5'd9
  } opcodeT;

  // Instruction phases
  typedef enum logic [1:0] {
    phaseIdle    = 2'd0,   // Waiting for an instruction
    phaseRead    = 2'd1,   // Register operands fetched
    phaseExecute = 2'd2,   // ALU result and flags captured
    phaseWrite   = 2'd3    // Result offered, written on transfer
  } phaseT;

endpackage

// File: cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

//////////////////////////////
// Datapath
//////////////////////////////

`define DATA_WIDTH 8       // One data word

// Register file geometry
`define REG_COUNT 16
`define REG_ADDR_WIDTH 4

//////////////////////////////
// Instruction fields
//////////////////////////////

`define OPCODE_WIDTH 5     // Opcode field of the 25-bit word

// Low operand bits taken as shift amount
`define SHIFT_WIDTH 3

`endif

// File: phaseSequencer.sv
`timescale 1ns/1ps

module phaseSequencer import cpu_pkg::*; (
  input  logic    clk,
  input  logic    Reset,
  // Instruction handshake
  input  logic    instrValid,
  output logic    instrReady,
  input  opcodeT  instrOpcode,
  input  regAddrT instrDest,
  input  regAddrT instrSrc1,
  input  regAddrT instrSrc2,
  input  dataT    instrImm,
  // Result handshake
  output logic    resultValid,
  input  logic    resultReady,
  output regAddrT resultDest,
  // Datapath controls
  output logic    readEnable,
  output regAddrT readAddr1,
  output regAddrT readAddr2,
  output logic    executeEnable,
  output opcodeT  latchedOpcode,
  output dataT    latchedImm,
  output logic    writeEnable
);

  phaseT phase;
  logic  instrAccept;
  logic  resultTransfer;

  //////////////////////////////
  // Handshakes and phase strobes
  //////////////////////////////

  assign instrReady     = (phase == phaseIdle);
  assign instrAccept    = instrValid && instrReady;
  assign resultValid    = (phase == phaseWrite);
  assign resultTransfer = resultValid && resultReady;

  assign readEnable    = (phase == phaseRead);
  assign executeEnable = (phase == phaseExecute);
  assign writeEnable   = resultTransfer;  // Register write at transfer edge

  //////////////////////////////
  // Phase register
  //////////////////////////////

  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      phase <= phaseIdle;
    end else begin
      case (phase)
        phaseIdle: begin
          if (instrAccept) begin
            phase <= phaseRead;
          end
        end
        phaseRead: begin
          phase <= phaseExecute;
        end
        phaseExecute: begin
          phase <= phaseWrite;
        end
        phaseWrite: begin
          // Back-pressure holds here
          if (resultTransfer) begin
            phase <= phaseIdle;
          end
        end
        default: begin
          phase <= phaseIdle;
        end
      endcase
    end
  end

  // Instruction latch, loaded only on acceptance
  always_ff @(posedge clk) begin
    if (instrAccept) begin
      latchedOpcode <= instrOpcode;
      latchedImm    <= instrImm;
      resultDest    <= instrDest;  // Stable through Write
      readAddr1     <= instrSrc1;
      readAddr2     <= instrSrc2;
    end
  end

endmodule

// File: project.f
+incdir+.
cpu_pkg.sv
phaseSequencer.sv
registerFile.sv
aluUnit.sv
cpuCore.sv
cpuCore_assertions.sv
tb_cpuCore.sv

// File: registerFile.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module registerFile import cpu_pkg::*; (
  input  logic    clk,
  input  logic    Reset,
  input  logic    readEnable,
  input  regAddrT readAddr1,
  input  regAddrT readAddr2,
  input  logic    writeEnable,
  input  regAddrT writeAddr,
  input  dataT    writeData,
  output dataT    readData1,
  output dataT    readData2
);

  dataT regs [`REG_COUNT];

  //////////////////////////////
  // Write port
  //////////////////////////////

  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable) begin
      regs[writeAddr] <= writeData;
    end
  end

  //////////////////////////////
  // Registered read ports
  //////////////////////////////

  // Captured on the edge leaving Read
  always_ff @(posedge clk) begin
    if (readEnable) begin
      readData1 <= regs[readAddr1];
      readData2 <= regs[readAddr2];  // Unused by immediate opcodes
    end
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the cpuCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_cpuCore -o simv \
  && ./obj_dir/simv | tee /dev/stderr | grep -qx "Done: no errors" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: tb_cpuCore.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module tb_cpuCore import cpu_pkg::*; ();

  localparam int resetCycles = 10;
  localparam int groupCount  = 30;
  localparam int mixedCount  = 200;
  localparam int instrTotal  = `REG_COUNT + 3 * groupCount + mixedCount + 2;
  localparam int cycleLimit  = instrTotal * 40 + 2 * resetCycles;

  logic clk, Reset, instrValid, instrReady, resultValid, resultReady;
  logic zeroFlag, carryFlag;
  opcodeT  instrOpcode;
  regAddrT instrDest, instrSrc1, instrSrc2, resultDest, lastDest;
  dataT    instrImm, resultData;
  dataT    modelRegs [`REG_COUNT];
  logic    modelZero, modelCarry;
  int seed = 39;
  int errorCount, checkCount, errorsAtStart, checksAtStart, cycleCount;

  cpuCore dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] nextRandom();
    return $random(seed);
  endfunction

  function automatic logic pickReady(input bit stall);
    logic [31:0] r;
    r = nextRandom();
    return stall ? (r[1:0] != 2'b00) : 1'b1;  // Roughly one stall in four
  endfunction

  function automatic opcodeT opFromIndex(input int unsigned idx);
    case (idx)
      0: return opAdd;
      1: return opSub;
      2: return opAddImm;
      3: return opSubImm;
      4: return opAnd;
      5: return opOr;
      6: return opXor;
      7: return opShl;
      8: return opShr;
      default: return opLoadImm;
    endcase
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic checkData(input dataT actual, input dataT expected, input string what);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic checkAddr(input regAddrT actual, input regAddrT expected, input string what);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  task automatic checkFlag(input logic actual, input logic expected, input string what);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, actual, expected);
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  task automatic computeExpected(input opcodeT op, input dataT a, input dataT regB,
                                 input dataT imm, output dataT value, output logic carry,
                                 output logic flagsUpdate);
    logic [`DATA_WIDTH:0] wide;
    wide = '0;
    value = imm;
    carry = 1'b0;
    flagsUpdate = 1'b1;
    case (op)
      opAdd:    wide = {1'b0, a} + {1'b0, regB};
      opAddImm: wide = {1'b0, a} + {1'b0, imm};
      opSub:    wide = {1'b0, a} + {1'b0, ~regB} + 1;  // Carry set means no borrow
      opSubImm: wide = {1'b0, a} + {1'b0, ~imm} + 1;
      opAnd:    value = a & regB;
      opOr:     value = a | regB;
      opXor:    value = a ^ regB;
      opShl: begin
        value = a << regB[`SHIFT_WIDTH-1:0];
        carry = a[`DATA_WIDTH-1];
      end
      opShr: begin
        value = a >> regB[`SHIFT_WIDTH-1:0];
        carry = a[0];
      end
      default: flagsUpdate = 1'b0;
    endcase
    if (op == opAdd || op == opAddImm || op == opSub || op == opSubImm) begin
      value = wide[`DATA_WIDTH-1:0];
      carry = wide[`DATA_WIDTH];
    end
  endtask

  // One instruction through both handshakes, checked at the result transfer
  task automatic execute(input opcodeT op, input regAddrT dest, input regAddrT src1,
                         input regAddrT src2, input dataT imm, input bit stall);
    dataT expValue;
    logic expCarry;
    logic expZero;
    logic flagsUpdate;
    int   waitCycles;
    computeExpected(op, modelRegs[src1], modelRegs[src2], imm, expValue, expCarry, flagsUpdate);
    expZero = flagsUpdate ? (expValue == '0) : modelZero;
    if (!flagsUpdate) expCarry = modelCarry;
    @(posedge clk);
    instrValid  <= 1'b1;
    instrOpcode <= op;
    instrDest   <= dest;
    instrSrc1   <= src1;
    instrSrc2   <= src2;
    instrImm    <= imm;
    @(negedge clk);
    while (!instrReady) @(negedge clk);
    @(posedge clk);  // Acceptance edge
    instrValid  <= 1'b0;
    resultReady <= pickReady(stall);
    @(negedge clk);
    waitCycles = 1;
    while (!(resultValid && resultReady)) begin
      @(posedge clk);
      resultReady <= pickReady(stall);
      @(negedge clk);
      waitCycles++;
    end
    if (!stall && waitCycles != 3) begin
      errorCount++;
      $display("Result latency wrong at %0t: %0d cycles instead of 3", $time, waitCycles);
    end
    checkData(resultData, expValue, "resultData");
    checkAddr(resultDest, dest, "resultDest");
    checkFlag(zeroFlag, expZero, "zeroFlag");
    checkFlag(carryFlag, expCarry, "carryFlag");
    modelRegs[dest] = expValue;
    modelZero = expZero;
    modelCarry = expCarry;
    @(posedge clk);  // Transfer edge
    resultReady <= 1'b0;
    @(negedge clk);
    checkFlag(instrReady, 1'b1, "instrReady after transfer");
    checkFlag(resultValid, 1'b0, "resultValid after transfer");
  endtask

  task automatic runGroup(input int unsigned base, input int unsigned span, input int count,
                          input bit stall, input bit chain);
    logic [31:0] rnd;
    regAddrT     src1;
    for (int i = 0; i < count; i++) begin
      rnd = nextRandom();
      src1 = rnd[7:4];
      if (chain && rnd[24]) src1 = lastDest;  // Read back the previous write
      execute(opFromIndex(base + (nextRandom() % span)), rnd[3:0], src1, rnd[15:12],
              rnd[23:16], stall);
      lastDest = rnd[3:0];
    end
  endtask

  task automatic clearModel();
    for (int i = 0; i < `REG_COUNT; i++) modelRegs[i] = '0;
    modelZero = 1'b0;
    modelCarry = 1'b0;
  endtask

  // Reset lands while an instruction is in flight
  task automatic resetMidRun();
    logic [31:0] rnd;
    rnd = nextRandom();
    @(posedge clk);
    instrValid  <= 1'b1;
    instrOpcode <= opAdd;
    instrDest   <= rnd[3:0];
    instrSrc1   <= rnd[7:4];
    instrSrc2   <= rnd[11:8];
    instrImm    <= rnd[19:12];
    @(negedge clk);
    while (!instrReady) @(negedge clk);
    @(posedge clk);
    instrValid <= 1'b0;
    @(posedge clk);
    Reset <= 1'b1;
    repeat (resetCycles) @(posedge clk);
    Reset <= 1'b0;
    clearModel();
    @(negedge clk);
    checkFlag(resultValid, 1'b0, "resultValid after reset");
    checkFlag(zeroFlag, 1'b0, "zeroFlag after reset");
    checkFlag(carryFlag, 1'b0, "carryFlag after reset");
    rnd = nextRandom();
    execute(opAdd, rnd[3:0], rnd[7:4], rnd[11:8], rnd[19:12], 1'b0);
    checkFlag(zeroFlag, 1'b1, "zeroFlag of add after reset");
  endtask

  task automatic finishTest(input int num, input string name);
    $display("Test %0d %s: %0d checks, %0d errors", num, name,
             checkCount - checksAtStart, errorCount - errorsAtStart);
    checksAtStart = checkCount;
    errorsAtStart = errorCount;
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    Reset = 1'b1;
    instrValid = 1'b0;
    instrOpcode = opLoadImm;
    instrDest = '0;
    instrSrc1 = '0;
    instrSrc2 = '0;
    instrImm = '0;
    resultReady = 1'b0;
    lastDest = '0;
    errorCount = 0;
    checkCount = 0;
    errorsAtStart = 0;
    checksAtStart = 0;
    clearModel();
    repeat (resetCycles) @(posedge clk);
    Reset <= 1'b0;
    for (int i = 0; i < `REG_COUNT; i++) begin
      execute(opLoadImm, regAddrT'(i), '0, '0, dataT'(nextRandom()), 1'b0);
    end
    finishTest(1, "load immediate");
    runGroup(0, 4, groupCount, 1'b0, 1'b0);
    finishTest(2, "add and subtract");
    runGroup(4, 3, groupCount, 1'b0, 1'b0);
    finishTest(3, "logic operations");
    runGroup(7, 2, groupCount, 1'b0, 1'b0);
    finishTest(4, "shifts");
    runGroup(0, 10, mixedCount, 1'b1, 1'b1);
    finishTest(5, "mixed with stalls");
    resetMidRun();
    finishTest(6, "reset mid run");
    $display("Totals: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) $display("Done: no errors");
    else $display("Done: errors found");
    $finish;
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: run did not finish within %0d cycles", cycleLimit);
    $display("Done: errors found");
    $finish;
  end

endmodule
